/* design/rhAddrDecode.sv */
/* Device bus decode. Turns a write strobe into same-cycle register selects,
   registers the read select for the read return and merges the clears. */

`timescale 1ns/1ps

module rhAddrDecode
(
   input  logic            clk,
   input  logic            rst,
   input  rhPkg::devBus_t  devBus,
   input  logic            devReset,
   input  logic            rhClr,
   output rhPkg::regSel_t  wrSel,
   output rhPkg::byteEn_t  byteEn,
   output rhPkg::regWord_t wrData,
   output logic            clr,
   output rhPkg::regSel_t  rdSel,
   output logic            rdPend
);
   import rhPkg::*;

   // Decoded offset, shared by both paths
   regSel_t offSel;

   always_comb
   begin
      offSel    = '0;
      offSel.wc = (devBus.offset == OFF_WC);
      offSel.ba = (devBus.offset == OFF_BA);
      offSel.db = (devBus.offset == OFF_DB);
   end

   // Write path, same cycle as the strobe
   assign wrSel     = devBus.wr ? offSel : '0;
   assign byteEn.hi = devBus.hiByte;
   assign byteEn.lo = devBus.loByte;

   // Ascending slice puts device bit 20 in register bit 15
   assign wrData = devBus.dataI[DEV_W-REG_W:DEV_W-1];

   // Device reset level or controller clear pulse
   assign clr = devReset | rhClr;

   // Read path, one stage
   // Unknown offset leaves an all-zero select
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdSel  <= '0;
         rdPend <= 1'b0;
      end
      else
      begin
         rdSel  <= devBus.rd ? offSel : '0;
         rdPend <= devBus.rd;
      end
   end

endmodule

/* design/rhBusAddr.sv */
/* Bus address register. Byte-writable and advanced by BA_STEP bytes on
   each transfer strobe, wrapping at 16 bits. */

`timescale 1ns/1ps

module rhBusAddr
#(
   parameter int BA_STEP = 2
)
(
   input  logic            clk,
   input  logic            rst,
   input  logic            clr,
   input  logic            wrEn,
   input  rhPkg::byteEn_t  byteEn,
   input  rhPkg::regWord_t wrData,
   input  logic            xferStb,
   output rhPkg::regWord_t ba
);
   import rhPkg::*;

   // Step sized to the register
   localparam regWord_t STEP = regWord_t'(BA_STEP);

   //////////////////////////////////////////////////////////////////////
   // Address register
   //////////////////////////////////////////////////////////////////////

   // Clear, then write, then transfer
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ba <= '0;
      end
      else if (clr)
      begin
         ba <= '0;
      end
      else if (wrEn)
      begin
         ba <= byteMerge(ba, wrData, byteEn);
      end
      else if (xferStb)
      begin
         // Natural 16 bit wrap
         ba <= ba + STEP;
      end
   end

endmodule

/* design/rhDb.sv */
/* Data buffer register. Loads the enabled byte lanes on a write and
   zeroes on a clear. */

`timescale 1ns/1ps

module rhDb
(
   input  logic            clk,
   input  logic            rst,
   input  logic            clr,
   input  logic            wrEn,
   input  rhPkg::byteEn_t  byteEn,
   input  rhPkg::regWord_t wrData,
   output rhPkg::regWord_t db
);
   import rhPkg::*;

   //////////////////////////////////////////////////////////////////////
   // Data buffer
   //////////////////////////////////////////////////////////////////////

   // Clear beats write
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         db <= '0;
      end
      else if (clr)
      begin
         db <= '0;
      end
      else if (wrEn)
      begin
         // Untouched lane keeps its byte
         db <= byteMerge(db, wrData, byteEn);
      end
   end

endmodule

/* design/rhPkg.sv */
/* Shared types, register offsets and the byte-lane merge helper for the
   disk controller register file. Imported by every design module. */

package rhPkg;

   //////////////////////////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////////////////////////

   localparam int REG_W = 16;
   localparam int DEV_W = 36;
   localparam int OFF_W = 3;

   // One register's contents
   typedef logic [REG_W-1:0] regWord_t;

   // Device word, numbered big-endian so bit 0 is the MSB
   // Register bits 15..0 ride on device bits 20..35, hence the swap
   typedef logic [0:DEV_W-1] devData_t;

   typedef logic [OFF_W-1:0] regOffset_t;

   // Register offsets, anything else reads zero and drops writes
   localparam regOffset_t OFF_WC = 3'd1;
   localparam regOffset_t OFF_BA = 3'd2;
   localparam regOffset_t OFF_DB = 3'd5;

   //////////////////////////////////////////////////////////////////////
   // Bus and select bundles
   //////////////////////////////////////////////////////////////////////

   // One device bus strobe
   typedef struct packed {
      logic       wr;
      logic       rd;
      logic       loByte;
      logic       hiByte;
      regOffset_t offset;
      devData_t   dataI;
   } devBus_t;

   // One-hot register select
   typedef struct packed {
      logic wc;
      logic ba;
      logic db;
   } regSel_t;

   typedef struct packed {
      logic hi;
      logic lo;
   } byteEn_t;

   // Loads only the enabled byte lanes
   function automatic regWord_t byteMerge(input regWord_t cur, input regWord_t wd,
                                          input byteEn_t be);
      regWord_t res;
      res = cur;
      if (be.hi)
      begin
         res[15:8] = wd[15:8];
      end
      if (be.lo)
      begin
         res[7:0] = wd[7:0];
      end
      return res;
   endfunction

endpackage

/* design/rhReadMux.sv */
/* Read return. Picks the register named by the registered read select and
   returns it one cycle later with a single-cycle acknowledge. */

`timescale 1ns/1ps

module rhReadMux
(
   input  logic            clk,
   input  logic            rst,
   input  rhPkg::regSel_t  rdSel,
   input  logic            rdPend,
   input  rhPkg::regWord_t wc,
   input  rhPkg::regWord_t ba,
   input  rhPkg::regWord_t db,
   output rhPkg::regWord_t rdData,
   output logic            rdAck
);
   import rhPkg::*;

   regWord_t selWord;

   // Zero when nothing is selected
   always_comb
   begin
      selWord = '0;
      if (rdSel.wc)
      begin
         selWord = wc;
      end
      else if (rdSel.ba)
      begin
         selWord = ba;
      end
      else if (rdSel.db)
      begin
         selWord = db;
      end
   end

   // Acknowledge tracks the pending read
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdAck <= 1'b0;
      end
      else
      begin
         rdAck <= rdPend;
      end
   end

   // Data holds between reads
   always_ff @(posedge clk)
   begin
      if (rdPend)
      begin
         rdData <= selWord;
      end
   end

endmodule

/* design/rhRegs.sv */
/* Register file top level. Joins the bus decode, the three registers and the
   read return. BA_STEP sets the bus address increment per transfer. */

`timescale 1ns/1ps

module rhRegs
#(
   parameter int BA_STEP = 2
)
(
   input  logic            clk,
   input  logic            rst,
   input  rhPkg::devBus_t  devBus,
   input  logic            devReset,
   input  logic            rhClr,
   input  logic            xferStb,
   output rhPkg::regWord_t rdData,
   output logic            rdAck,
   output rhPkg::regWord_t wc,
   output rhPkg::regWord_t ba,
   output rhPkg::regWord_t db,
   output logic            wcOvf
);
   import rhPkg::*;

   //////////////////////////////////////////////////////////////////////
   // Internal wiring
   //////////////////////////////////////////////////////////////////////

   regSel_t  wrSel;
   byteEn_t  byteEn;
   regWord_t wrData;
   logic     clr;
   regSel_t  rdSel;
   logic     rdPend;

   // Decode
   rhAddrDecode decode0 (.clk(clk), .rst(rst), .devBus(devBus), .devReset(devReset),
                         .rhClr(rhClr), .wrSel(wrSel), .byteEn(byteEn),
                         .wrData(wrData), .clr(clr), .rdSel(rdSel), .rdPend(rdPend));

   // Registers
   rhDb db0 (.clk(clk), .rst(rst), .clr(clr), .wrEn(wrSel.db), .byteEn(byteEn),
             .wrData(wrData), .db(db));

   rhWordCount wc0 (.clk(clk), .rst(rst), .clr(clr), .wrEn(wrSel.wc), .byteEn(byteEn),
                    .wrData(wrData), .xferStb(xferStb), .wc(wc), .wcOvf(wcOvf));

   rhBusAddr #(.BA_STEP(BA_STEP)) ba0 (.clk(clk), .rst(rst), .clr(clr),
                                       .wrEn(wrSel.ba), .byteEn(byteEn),
                                       .wrData(wrData), .xferStb(xferStb),
                                       .ba(ba));

   // Read return
   rhReadMux rdMux0 (.clk(clk), .rst(rst), .rdSel(rdSel), .rdPend(rdPend),
                     .wc(wc), .ba(ba), .db(db), .rdData(rdData), .rdAck(rdAck));

endmodule

/* design/rhWordCount.sv */
/* Word count register. Byte-writable, counts up once per transfer strobe
   and holds a sticky flag when the count wraps to zero. */

`timescale 1ns/1ps

module rhWordCount
(
   input  logic            clk,
   input  logic            rst,
   input  logic            clr,
   input  logic            wrEn,
   input  rhPkg::byteEn_t  byteEn,
   input  rhPkg::regWord_t wrData,
   input  logic            xferStb,
   output rhPkg::regWord_t wc,
   output logic            wcOvf
);
   import rhPkg::*;

   // Count sits at all-ones on this transfer
   logic wcWrap;

   assign wcWrap = xferStb & (wc == '1);

   //////////////////////////////////////////////////////////////////////
   // Count and overflow
   //////////////////////////////////////////////////////////////////////

   // Clear, then write, then transfer
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wc    <= '0;
         wcOvf <= 1'b0;
      end
      else if (clr)
      begin
         wc    <= '0;
         wcOvf <= 1'b0;
      end
      else if (wrEn)
      begin
         // New count from software drops any old overflow
         wc    <= byteMerge(wc, wrData, byteEn);
         wcOvf <= 1'b0;
      end
      else if (xferStb)
      begin
         // Loaded negative, counts toward zero
         wc <= wc + 1'b1;
         if (wcWrap)
         begin
            wcOvf <= 1'b1;
         end
      end
   end

endmodule

/* project.f */
design/rhPkg.sv
design/rhAddrDecode.sv
design/rhDb.sv
design/rhWordCount.sv
design/rhBusAddr.sv
design/rhReadMux.sv
design/rhRegs.sv
sim/rhRegs_properties.sv
sim/rhRegsTb.sv

/* sim/rhRegsTb.sv */
/* Table-driven testbench for the register file. Each row runs against a
   reference model; register outputs and read returns are compared. */

`timescale 1ns/1ps

module rhRegsTb;
   import rhPkg::*;

   localparam int BA_STEP  = 2;
   localparam int NROWS    = 30;
   localparam int RD_LIMIT = 20;

   // Row operations
   localparam logic [2:0] OP_WR    = 3'd0;
   localparam logic [2:0] OP_RD    = 3'd1;
   localparam logic [2:0] OP_RDB   = 3'd2;
   localparam logic [2:0] OP_XF    = 3'd3;
   localparam logic [2:0] OP_CLR   = 3'd4;
   localparam logic [2:0] OP_DRST  = 3'd5;
   localparam logic [2:0] OP_CLRWR = 3'd6;

   typedef struct packed {
      logic [2:0] op;
      regOffset_t offset;
      logic       hi;
      logic       lo;
      logic       rnd;
      regWord_t   data;
   } stimRow_t;

   logic     clk;
   logic     rst;
   devBus_t  devBus;
   logic     devReset;
   logic     rhClr;
   logic     xferStb;
   regWord_t rdData;
   logic     rdAck;
   regWord_t wc;
   regWord_t ba;
   regWord_t db;
   logic     wcOvf;

   stimRow_t    stim [NROWS];
   regWord_t    mWc;
   regWord_t    mBa;
   regWord_t    mDb;
   logic        mOvf;
   logic [31:0] lfsr;
   int          errCnt;
   int          checkCnt;
   int          rowErr;
   regOffset_t  rdOffs [4];
   regWord_t    expQ [4];
   int          expCyc [4];
   int          expHead;
   int          expTail;

   rhRegs #(.BA_STEP(BA_STEP)) dut0 (.clk(clk), .rst(rst), .devBus(devBus),
      .devReset(devReset), .rhClr(rhClr), .xferStb(xferStb), .rdData(rdData),
      .rdAck(rdAck), .wc(wc), .ba(ba), .db(db), .wcOvf(wcOvf));

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   // Galois form with taps for x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsrNext(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
      begin
         n = n ^ 32'h80200003;
      end
      return n;
   endfunction

   task automatic takeByte(output logic [7:0] b);
      for (int i = 0; i < 8; i++)
      begin
         b[i] = lfsr[0];
         lfsr = lfsrNext(lfsr);
      end
   endtask

   function automatic stimRow_t mkRow(input logic [2:0] op, input regOffset_t off,
                                      input logic hi, input logic lo, input logic rnd,
                                      input regWord_t data);
      stimRow_t r;
      r = '{op, off, hi, lo, rnd, data};
      return r;
   endfunction

   // Register word onto the big-endian device word with filler in the unused bits
   function automatic devData_t toDev(input regWord_t w);
      devData_t d;
      d[0:19] = 20'h5a5a5;
      for (int i = 0; i < 16; i++)
      begin
         d[20+i] = w[15-i];
      end
      return d;
   endfunction

   function automatic regWord_t laneLoad(input regWord_t cur, input regWord_t wd,
                                         input logic hi, input logic lo);
      return {hi ? wd[15:8] : cur[15:8], lo ? wd[7:0] : cur[7:0]};
   endfunction

   function automatic regWord_t modelRead(input regOffset_t off);
      return (off == OFF_WC) ? mWc : (off == OFF_BA) ? mBa : (off == OFF_DB) ? mDb : '0;
   endfunction

   function automatic string opName(input logic [2:0] op);
      string s [7] = '{"write", "read", "read burst", "transfer", "clear", "dev reset",
                       "clear+write"};
      return s[op];
   endfunction

   task automatic checkWord(input string name, input regWord_t got, input regWord_t exp);
      checkCnt++;
      if (got !== exp)
      begin
         $display("ERR %s got %h exp %h", name, got, exp);
         errCnt++;
         rowErr++;
      end
   endtask

   task automatic checkFlag(input string name, input bit got, input bit exp);
      checkCnt++;
      if (got !== exp)
      begin
         $display("ERR %s got %h exp %h", name, got, exp);
         errCnt++;
         rowErr++;
      end
   endtask

   task automatic checkRegs();
      checkWord("wc", wc, mWc);
      checkWord("ba", ba, mBa);
      checkWord("db", db, mDb);
      checkFlag("wcOvf", wcOvf, mOvf);
   endtask

   task automatic driveIdle();
      devBus   = '0;
      devReset = 1'b0;
      rhClr    = 1'b0;
      xferStb  = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Row execution
   //////////////////////////////////////////////////////////////////////

   // Pops one expected word when the acknowledge is up
   task automatic takeAck(input int cyc);
      if (rdAck && expHead == expTail)
      begin
         $display("rdAck seen with no read outstanding");
         errCnt++;
         rowErr++;
      end
      else if (rdAck)
      begin
         if (cyc != expCyc[expHead])
         begin
            $display("rdAck for read %0d came in cycle %0d instead of cycle %0d",
                     expHead, cyc, expCyc[expHead]);
            errCnt++;
            rowErr++;
         end
         checkWord("rdData", rdData, expQ[expHead]);
         expHead++;
      end
   endtask

   // Back to back strobes with acks drained in order
   task automatic runReads(input int n);
      int idleCnt;
      int cyc;
      expHead = 0;
      expTail = 0;
      for (int i = 0; i < n; i++)
      begin
         @(posedge clk);
         #1;
         devBus        = '0;
         devBus.rd     = 1'b1;
         devBus.offset = rdOffs[i];
         expQ[expTail] = modelRead(rdOffs[i]);
         // Strobe in cycle i returns in cycle i+2
         expCyc[expTail] = i + 2;
         expTail++;
         @(negedge clk);
         takeAck(i);
      end
      @(posedge clk);
      #1;
      driveIdle();
      idleCnt = 0;
      cyc     = n;
      while (expHead < expTail)
      begin
         @(negedge clk);
         idleCnt = rdAck ? 0 : idleCnt + 1;
         takeAck(cyc);
         cyc++;
         if (idleCnt > RD_LIMIT)
         begin
            $display("timeout waiting for rdAck after %0d cycles", RD_LIMIT);
            $display("test failed");
            $finish;
         end
      end
   endtask

   task automatic applyRow(input stimRow_t r);
      regWord_t   wd;
      logic [7:0] bHi;
      logic [7:0] bLo;
      wd = r.data;
      if (r.rnd)
      begin
         takeByte(bHi);
         takeByte(bLo);
         wd = {bHi, bLo};
      end
      @(posedge clk);
      #1;
      devBus.wr     = (r.op == OP_WR || r.op == OP_CLRWR);
      devBus.hiByte = r.hi;
      devBus.loByte = r.lo;
      devBus.offset = r.offset;
      devBus.dataI  = toDev(wd);
      xferStb       = (r.op == OP_XF);
      rhClr         = (r.op == OP_CLR || r.op == OP_CLRWR);
      devReset      = (r.op == OP_DRST);
      @(posedge clk);
      #1;
      driveIdle();
      // Model applies clear first, then write, then transfer
      if (r.op == OP_CLR || r.op == OP_DRST || r.op == OP_CLRWR)
      begin
         {mWc, mBa, mDb, mOvf} = '0;
      end
      else if (r.op == OP_WR)
      begin
         mWc  = (r.offset == OFF_WC) ? laneLoad(mWc, wd, r.hi, r.lo) : mWc;
         mOvf = (r.offset == OFF_WC) ? 1'b0 : mOvf;
         mBa  = (r.offset == OFF_BA) ? laneLoad(mBa, wd, r.hi, r.lo) : mBa;
         mDb  = (r.offset == OFF_DB) ? laneLoad(mDb, wd, r.hi, r.lo) : mDb;
      end
      else if (r.op == OP_XF)
      begin
         mOvf = mOvf | (mWc == 16'hffff);
         mWc  = mWc + 16'd1;
         mBa  = mBa + 16'(BA_STEP);
      end
      @(negedge clk);
      checkRegs();
      checkFlag("rdAck", rdAck, 1'b0);
   endtask

   task automatic fillStim();
      stim[0]  = mkRow(OP_WR,    OFF_DB, 1, 0, 1, 16'h0000);
      stim[1]  = mkRow(OP_RD,    OFF_DB, 0, 0, 0, 16'h0000);
      stim[2]  = mkRow(OP_WR,    OFF_DB, 0, 1, 1, 16'h0000);
      stim[3]  = mkRow(OP_RD,    OFF_DB, 0, 0, 0, 16'h0000);
      stim[4]  = mkRow(OP_WR,    OFF_DB, 1, 1, 0, 16'hbeef);
      stim[5]  = mkRow(OP_RD,    OFF_DB, 0, 0, 0, 16'h0000);
      stim[6]  = mkRow(OP_WR,    OFF_WC, 1, 1, 0, 16'hfffd);
      stim[7]  = mkRow(OP_WR,    OFF_BA, 1, 1, 0, 16'h1000);
      stim[8]  = mkRow(OP_XF,    3'd0,   0, 0, 0, 16'h0000);
      stim[9]  = mkRow(OP_XF,    3'd0,   0, 0, 0, 16'h0000);
      // Burst ends on an unknown offset
      stim[10] = mkRow(OP_RDB,   3'd7,   0, 0, 0, 16'h0000);
      stim[11] = mkRow(OP_WR,    OFF_BA, 1, 0, 1, 16'h0000);
      stim[12] = mkRow(OP_XF,    3'd0,   0, 0, 0, 16'h0000);
      stim[13] = mkRow(OP_RD,    OFF_WC, 0, 0, 0, 16'h0000);
      stim[14] = mkRow(OP_XF,    3'd0,   0, 0, 0, 16'h0000);
      stim[15] = mkRow(OP_WR,    OFF_WC, 0, 1, 0, 16'h0012);
      stim[16] = mkRow(OP_WR,    OFF_DB, 1, 1, 1, 16'h0000);
      stim[17] = mkRow(OP_CLR,   3'd0,   0, 0, 0, 16'h0000);
      stim[18] = mkRow(OP_WR,    OFF_WC, 1, 1, 1, 16'h0000);
      stim[19] = mkRow(OP_WR,    OFF_BA, 1, 1, 1, 16'h0000);
      stim[20] = mkRow(OP_WR,    OFF_DB, 1, 1, 1, 16'h0000);
      stim[21] = mkRow(OP_XF,    3'd0,   0, 0, 0, 16'h0000);
      stim[22] = mkRow(OP_DRST,  3'd0,   0, 0, 0, 16'h0000);
      stim[23] = mkRow(OP_WR,    OFF_DB, 1, 1, 0, 16'h5555);
      stim[24] = mkRow(OP_CLRWR, OFF_DB, 1, 1, 0, 16'haaaa);
      stim[25] = mkRow(OP_RDB,   3'd0,   0, 0, 0, 16'h0000);
      stim[26] = mkRow(OP_WR,    OFF_WC, 1, 1, 0, 16'hffff);
      stim[27] = mkRow(OP_XF,    3'd0,   0, 0, 0, 16'h0000);
      stim[28] = mkRow(OP_CLR,   3'd0,   0, 0, 0, 16'h0000);
      stim[29] = mkRow(OP_RD,    OFF_WC, 0, 0, 0, 16'h0000);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      lfsr     = 32'h21d3;
      errCnt   = 0;
      checkCnt = 0;
      rowErr   = 0;
      rst      = 1'b1;
      driveIdle();
      fillStim();
      {mWc, mBa, mDb, mOvf} = '0;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      checkRegs();
      checkFlag("rdAck", rdAck, 1'b0);
      for (int r = 0; r < NROWS; r++)
      begin
         rowErr = 0;
         if (stim[r].op == OP_RDB)
         begin
            rdOffs = '{OFF_WC, OFF_BA, OFF_DB, stim[r].offset};
            runReads(4);
         end
         else if (stim[r].op == OP_RD)
         begin
            rdOffs[0] = stim[r].offset;
            runReads(1);
         end
         else
         begin
            applyRow(stim[r]);
         end
         $display("row %0d %s: %s", r, opName(stim[r].op), (rowErr == 0) ? "ok" : "mismatch");
      end
      errCnt = errCnt + dut0.props0.failCnt;
      $display("rows %0d checks %0d errors %0d", NROWS, checkCnt, errCnt);
      if (errCnt == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* sim/rhRegs_properties.sv */
/* Concurrent checks bound into the register file top level.
   Covers read latency, clear behaviour and the write select. */

`timescale 1ns/1ps

module rhRegsProps
(
   input logic            clk,
   input logic            rst,
   input rhPkg::devBus_t  devBus,
   input logic            clr,
   input rhPkg::regSel_t  wrSel,
   input logic            rdAck,
   input rhPkg::regWord_t wc,
   input logic            wcOvf,
   input rhPkg::regWord_t ba,
   input rhPkg::regWord_t db
);

   // Failed assertions, read by the testbench summary
   int failCnt = 0;

   // Read strobe returns exactly two edges later
   rdLatency: assert property (@(posedge clk) disable iff (rst) devBus.rd |-> ##2 rdAck)
      else
      begin
         $error("rdAck missing two cycles after a read strobe");
         failCnt++;
      end
   rdAckCause: assert property (@(posedge clk) disable iff (rst) rdAck |-> $past(devBus.rd, 2))
      else
      begin
         $error("rdAck without a read strobe two cycles before");
         failCnt++;
      end

   // Clear empties everything at the next edge
   clrZero: assert property (@(posedge clk) disable iff (rst)
      clr |=> (wc == '0 && ba == '0 && db == '0 && !wcOvf))
      else
      begin
         $error("registers not zero after clear");
         failCnt++;
      end

   wrSelOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(wrSel))
      else
      begin
         $error("write select not one-hot");
         failCnt++;
      end

endmodule

bind rhRegs rhRegsProps props0 (.clk(clk), .rst(rst), .devBus(devBus), .clr(clr),
                                .wrSel(wrSel), .rdAck(rdAck), .wc(wc), .wcOvf(wcOvf),
                                .ba(ba), .db(db));
